// File: soc_misc_params.svh
// soc misc constants
`ifndef SOC_MISC_PARAMS_SVH
`define SOC_MISC_PARAMS_SVH

// address bits 31:28
`define SOC_REGION_UART  4'h1
`define SOC_REGION_MISC  4'h2
`define SOC_REGION_LCD   4'h3
`define SOC_REGION_RAM   4'h4
`define SOC_REGION_REND  4'h5
`define SOC_REGION_USB   4'h6
`define SOC_REGION_PIC   4'h7
`define SOC_REGION_AUDIO 4'h8
`define SOC_REGION_PSRAM 4'h9

// misc register index, address bits 6:2
`define SOC_REG_LED       5'd0
`define SOC_REG_BTN       5'd1
`define SOC_REG_SOC_VER   5'd2
`define SOC_REG_FLASH_SEL 5'd13
`define SOC_REG_GENIO_IN  5'd17
`define SOC_REG_GENIO_OUT 5'd18
`define SOC_REG_GENIO_OE  5'd19
`define SOC_REG_GENIO_W2S 5'd20
`define SOC_REG_GENIO_W2C 5'd21

// upper bits of a flash select write that queue a reload
`define SOC_FSEL_KEY    24'hD0F1A5
`define SOC_FSEL_START  3'd7
`define SOC_FSEL_HI_MAX 3'd5
`define SOC_FSEL_HI_MIN 3'd3

`define SOC_ERR_WORD 32'hDEADBEEF
`define SOC_VERSION  32'h0000_8000

`define SOC_GENIO_W     30
`define SOC_LED_W       16
`define SOC_BTN_W       8
`define SOC_IRQ_BUSERR  3
`define SOC_IRQ_EXT_LSB 4
`define SOC_IRQ_EXT_W   3

`endif

// File: soc_bus_pkg.sv
// system bus types
`include "soc_misc_params.svh"

package soc_bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	// all zero means a read
	typedef logic [3:0] bus_strb_t;
	typedef logic [31:0] irq_vec_t;

	// only misc is served, the rest decode to a bus error
	typedef enum logic [3:0] {
		REGION_NONE  = 4'h0,
		REGION_UART  = `SOC_REGION_UART,
		REGION_MISC  = `SOC_REGION_MISC,
		REGION_LCD   = `SOC_REGION_LCD,
		REGION_RAM   = `SOC_REGION_RAM,
		REGION_REND  = `SOC_REGION_REND,
		REGION_USB   = `SOC_REGION_USB,
		REGION_PIC   = `SOC_REGION_PIC,
		REGION_AUDIO = `SOC_REGION_AUDIO,
		REGION_PSRAM = `SOC_REGION_PSRAM
	} bus_region_e;

endpackage

// File: soc_misc_pkg.sv
// misc register block types
`include "soc_misc_params.svh"

package soc_misc_pkg;

	// indexes not listed read zero and drop writes
	typedef enum logic [4:0] {
		REG_LED       = `SOC_REG_LED,
		REG_BTN       = `SOC_REG_BTN,
		REG_SOC_VER   = `SOC_REG_SOC_VER,
		REG_FLASH_SEL = `SOC_REG_FLASH_SEL,
		REG_GENIO_IN  = `SOC_REG_GENIO_IN,
		REG_GENIO_OUT = `SOC_REG_GENIO_OUT,
		REG_GENIO_OE  = `SOC_REG_GENIO_OE,
		REG_GENIO_W2S = `SOC_REG_GENIO_W2S,
		REG_GENIO_W2C = `SOC_REG_GENIO_W2C
	} misc_reg_e;

	// flash select countdown
	typedef enum logic [1:0] {
		FSEL_IDLE   = 2'd0,
		FSEL_COUNT  = 2'd1,
		FSEL_RELOAD = 2'd2
	} fsel_state_e;

endpackage

// File: bus_decode.sv
// bus request decoder
`include "soc_misc_params.svh"

module bus_decode
	import soc_bus_pkg::*, soc_misc_pkg::*;
(
	input  logic      clk48m,
	input  logic      rst,
	input  logic      i_valid,
	input  bus_addr_t i_addr,
	input  bus_data_t i_wdata,
	input  bus_strb_t i_wstrb,
	output logic      o_wr_en,
	output logic      o_rd_en,
	output logic      o_err,
	output misc_reg_e o_reg,
	output bus_data_t o_wdata
);

	logic        busy;
	logic        accept;
	logic        misc_hit;
	bus_region_e region;

	assign region   = bus_region_e'(i_addr[31:28]);
	assign misc_hit = (region == REGION_MISC);
	// first cycle of a held valid only
	assign accept   = i_valid && !busy;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			busy    <= 1'b0;
			o_wr_en <= 1'b0;
			o_rd_en <= 1'b0;
			o_err   <= 1'b0;
		end else begin
			o_wr_en <= accept && misc_hit && (i_wstrb != '0);
			o_rd_en <= accept && misc_hit && (i_wstrb == '0);
			o_err   <= accept && !misc_hit;
			// stays busy until the master lets go of valid
			if (!i_valid)
				busy <= 1'b0;
			else if (accept)
				busy <= 1'b1;
		end
	end

	always_ff @(posedge clk48m) begin
		if (accept) begin
			o_reg   <= misc_reg_e'(i_addr[6:2]);
			o_wdata <= i_wdata;
		end
	end

endmodule

// File: reg_execute.sv
// misc register write logic
`include "soc_misc_params.svh"

module reg_execute
	import soc_bus_pkg::*, soc_misc_pkg::*;
(
	input  logic                    clk48m,
	input  logic                    rst,
	input  logic                    i_wr_en,
	input  misc_reg_e               i_reg,
	input  bus_data_t               i_wdata,
	output logic [`SOC_LED_W-1:0]   o_led,
	output logic [`SOC_GENIO_W-1:0] o_genio_out,
	output logic [`SOC_GENIO_W-1:0] o_genio_oe,
	output logic                    o_fsel_d,
	output logic                    o_fsel_strobe,
	output logic                    o_fsel_key
);

	logic [`SOC_GENIO_W-1:0] genio_wr;

	assign genio_wr = i_wdata[`SOC_GENIO_W-1:0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			o_led         <= '0;
			o_genio_out   <= '0;
			o_genio_oe    <= '0;
			o_fsel_d      <= 1'b0;
			o_fsel_strobe <= 1'b0;
		end else begin
			o_fsel_strobe <= i_wr_en && (i_reg == REG_FLASH_SEL);
			if (i_wr_en) begin
				case (i_reg)
					REG_LED: o_led <= i_wdata[`SOC_LED_W-1:0];
					REG_FLASH_SEL: o_fsel_d <= i_wdata[0];
					REG_GENIO_OUT: o_genio_out <= genio_wr;
					REG_GENIO_OE: o_genio_oe <= genio_wr;
					// set and clear only touch bits written as one
					REG_GENIO_W2S: o_genio_out <= o_genio_out | genio_wr;
					REG_GENIO_W2C: o_genio_out <= o_genio_out & ~genio_wr;
					// read-only and unknown indexes
					default: ;
				endcase
			end
		end
	end

	// upper bits compared against the reload key
	always_ff @(posedge clk48m) begin
		o_fsel_key <= (i_wdata[31:8] == `SOC_FSEL_KEY);
	end

endmodule

// File: fsel_sequencer.sv
// flash select sequencer
`include "soc_misc_params.svh"

module fsel_sequencer
	import soc_misc_pkg::*;
(
	input  logic clk48m,
	input  logic rst,
	input  logic i_strobe,
	input  logic i_key,
	output logic o_fsel_c,
	output logic o_programn
);

	fsel_state_e state;
	logic [2:0]  count;
	logic        reload_queued;

	// clock the flash mux flop well after its data line settles
	assign o_fsel_c = (state == FSEL_COUNT) &&
		(count <= `SOC_FSEL_HI_MAX) && (count >= `SOC_FSEL_HI_MIN);
	assign o_programn = (state != FSEL_RELOAD);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			state         <= FSEL_IDLE;
			count         <= '0;
			reload_queued <= 1'b0;
		end else begin
			if (i_strobe && i_key)
				reload_queued <= 1'b1;
			case (state)
				FSEL_IDLE: begin
					if (i_strobe) begin
						count <= `SOC_FSEL_START;
						state <= FSEL_COUNT;
					end
				end
				FSEL_COUNT: begin
					if (i_strobe) begin
						count <= `SOC_FSEL_START;
					end else if (count == 3'd1) begin
						count <= '0;
						state <= reload_queued ? FSEL_RELOAD : FSEL_IDLE;
					end else begin
						count <= count - 3'd1;
					end
				end
				// programn held low until reset
				default: state <= FSEL_RELOAD;
			endcase
		end
	end

endmodule

// File: read_result.sv
// bus response and irq
`include "soc_misc_params.svh"

module read_result
	import soc_bus_pkg::*, soc_misc_pkg::*;
(
	input  logic                      clk48m,
	input  logic                      rst,
	input  logic                      i_rd_en,
	input  logic                      i_wr_en,
	input  logic                      i_err,
	input  misc_reg_e                 i_reg,
	input  logic [`SOC_LED_W-1:0]     i_led,
	input  logic [`SOC_GENIO_W-1:0]   i_genio_out,
	input  logic [`SOC_GENIO_W-1:0]   i_genio_oe,
	input  logic                      i_fsel_d,
	input  logic [`SOC_BTN_W-1:0]     i_btn,
	input  logic [`SOC_GENIO_W-1:0]   i_genio_in,
	input  logic [`SOC_IRQ_EXT_W-1:0] i_irq_ext,
	output logic                      o_ready,
	output bus_data_t                 o_rdata,
	output irq_vec_t                  o_irq
);

	bus_data_t             rd_word;
	logic                  err_q;
	logic [`SOC_BTN_W-1:0] btn_n;

	// buttons are active low on the board
	assign btn_n = ~i_btn;

	always_comb begin
		case (i_reg)
			REG_LED: rd_word = bus_data_t'(i_led);
			REG_BTN: rd_word = bus_data_t'(btn_n);
			REG_SOC_VER: rd_word = `SOC_VERSION;
			REG_FLASH_SEL: rd_word = bus_data_t'(i_fsel_d);
			REG_GENIO_IN: rd_word = bus_data_t'(i_genio_in);
			REG_GENIO_OUT: rd_word = bus_data_t'(i_genio_out);
			REG_GENIO_OE: rd_word = bus_data_t'(i_genio_oe);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			o_ready <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			o_ready <= i_rd_en || i_wr_en || i_err;
			err_q   <= i_err;
		end
	end

	always_ff @(posedge clk48m) begin
		if (i_err)
			o_rdata <= `SOC_ERR_WORD;
		else if (i_rd_en)
			o_rdata <= rd_word;
		else if (i_wr_en)
			o_rdata <= '0;
	end

	// bus error only flags during its own response
	always_comb begin
		o_irq = '0;
		o_irq[`SOC_IRQ_BUSERR] = err_q;
		o_irq[`SOC_IRQ_EXT_LSB +: `SOC_IRQ_EXT_W] = i_irq_ext;
	end

endmodule

// File: soc_misc.sv
// soc misc slice top
`include "soc_misc_params.svh"

module soc_misc
	import soc_bus_pkg::*, soc_misc_pkg::*;
(
	input  logic                      clk48m,
	input  logic                      rst,
	input  logic                      i_valid,
	input  bus_addr_t                 i_addr,
	input  bus_data_t                 i_wdata,
	input  bus_strb_t                 i_wstrb,
	output bus_data_t                 o_rdata,
	output logic                      o_ready,
	output logic [`SOC_LED_W-1:0]     o_led,
	output logic [`SOC_GENIO_W-1:0]   o_genio_out,
	output logic [`SOC_GENIO_W-1:0]   o_genio_oe,
	output logic                      o_fsel_d,
	output logic                      o_fsel_c,
	output logic                      o_programn,
	output irq_vec_t                  o_irq,
	input  logic [`SOC_BTN_W-1:0]     i_btn,
	input  logic [`SOC_GENIO_W-1:0]   i_genio_in,
	// usb, copper, audio
	input  logic [`SOC_IRQ_EXT_W-1:0] i_irq_ext
);

	logic      wr_en;
	logic      rd_en;
	logic      err;
	misc_reg_e reg_sel;
	bus_data_t wdata;
	logic      fsel_strobe;
	logic      fsel_key;

	bus_decode bus_decode_i (
		.clk48m  (clk48m),
		.rst     (rst),
		.i_valid (i_valid),
		.i_addr  (i_addr),
		.i_wdata (i_wdata),
		.i_wstrb (i_wstrb),
		.o_wr_en (wr_en),
		.o_rd_en (rd_en),
		.o_err   (err),
		.o_reg   (reg_sel),
		.o_wdata (wdata)
	);

	reg_execute reg_execute_i (
		.clk48m        (clk48m),
		.rst           (rst),
		.i_wr_en       (wr_en),
		.i_reg         (reg_sel),
		.i_wdata       (wdata),
		.o_led         (o_led),
		.o_genio_out   (o_genio_out),
		.o_genio_oe    (o_genio_oe),
		.o_fsel_d      (o_fsel_d),
		.o_fsel_strobe (fsel_strobe),
		.o_fsel_key    (fsel_key)
	);

	fsel_sequencer fsel_sequencer_i (
		.clk48m     (clk48m),
		.rst        (rst),
		.i_strobe   (fsel_strobe),
		.i_key      (fsel_key),
		.o_fsel_c   (o_fsel_c),
		.o_programn (o_programn)
	);

	read_result read_result_i (
		.clk48m      (clk48m),
		.rst         (rst),
		.i_rd_en     (rd_en),
		.i_wr_en     (wr_en),
		.i_err       (err),
		.i_reg       (reg_sel),
		.i_led       (o_led),
		.i_genio_out (o_genio_out),
		.i_genio_oe  (o_genio_oe),
		.i_fsel_d    (o_fsel_d),
		.i_btn       (i_btn),
		.i_genio_in  (i_genio_in),
		.i_irq_ext   (i_irq_ext),
		.o_ready     (o_ready),
		.o_rdata     (o_rdata),
		.o_irq       (o_irq)
	);

endmodule

// File: soc_misc_asserts.sv
// bus and flash select assertions
module soc_misc_asserts (
	input logic clk48m,
	input logic rst,
	input logic i_valid,
	input logic o_ready,
	input logic o_fsel_c,
	input logic o_programn
);
	timeunit 1ns;
	timeprecision 1ps;

	// one response beat per request
	ready_one_cycle: assert property (@(posedge clk48m) disable iff (rst)
		o_ready |=> !o_ready)
		else $error("o_ready stayed high for more than one cycle");

	ready_after_valid: assert property (@(posedge clk48m) disable iff (rst)
		o_ready |-> $past(i_valid))
		else $error("o_ready without a preceding valid request");

	// clock pulse spans counts 5 to 3 only
	fsel_c_short: assert property (@(posedge clk48m) disable iff (rst)
		!(o_fsel_c && $past(o_fsel_c) && $past(o_fsel_c, 2) && $past(o_fsel_c, 3)))
		else $error("o_fsel_c high for more than 3 cycles");

	programn_no_rise: assert property (@(posedge clk48m) disable iff (rst)
		!$rose(o_programn))
		else $error("o_programn rose after going low");

endmodule

bind soc_misc soc_misc_asserts soc_misc_asserts_i (
	.clk48m     (clk48m),
	.rst        (rst),
	.i_valid    (i_valid),
	.o_ready    (o_ready),
	.o_fsel_c   (o_fsel_c),
	.o_programn (o_programn)
);

// File: tb_soc_misc.sv
// soc misc testbench
`include "soc_misc_params.svh"

module tb_soc_misc
	import soc_bus_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic                      clk48m;
	logic                      rst;
	logic                      i_valid;
	bus_addr_t                 i_addr;
	bus_data_t                 i_wdata;
	bus_strb_t                 i_wstrb;
	logic [`SOC_BTN_W-1:0]     i_btn;
	logic [`SOC_GENIO_W-1:0]   i_genio_in;
	logic [`SOC_IRQ_EXT_W-1:0] i_irq_ext;
	bus_data_t                 o_rdata;
	logic                      o_ready;
	logic [`SOC_LED_W-1:0]     o_led;
	logic [`SOC_GENIO_W-1:0]   o_genio_out;
	logic [`SOC_GENIO_W-1:0]   o_genio_oe;
	logic                      o_fsel_d;
	logic                      o_fsel_c;
	logic                      o_programn;
	irq_vec_t                  o_irq;

	integer      seed;
	logic [31:0] rnd;

	// reference model state
	logic [`SOC_LED_W-1:0]     m_led;
	logic [`SOC_GENIO_W-1:0]   m_out;
	logic [`SOC_GENIO_W-1:0]   m_oe;
	logic                      m_fsel_d;
	// input values driven with the current request
	logic [`SOC_BTN_W-1:0]     btn_v;
	logic [`SOC_GENIO_W-1:0]   gin_v;
	logic [`SOC_IRQ_EXT_W-1:0] ext_v;

	soc_misc soc_misc_i (
		.clk48m      (clk48m),
		.rst         (rst),
		.i_valid     (i_valid),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.i_wstrb     (i_wstrb),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.o_led       (o_led),
		.o_genio_out (o_genio_out),
		.o_genio_oe  (o_genio_oe),
		.o_fsel_d    (o_fsel_d),
		.o_fsel_c    (o_fsel_c),
		.o_programn  (o_programn),
		.o_irq       (o_irq),
		.i_btn       (i_btn),
		.i_genio_in  (i_genio_in),
		.i_irq_ext   (i_irq_ext)
	);

	initial begin
		clk48m = 1'b0;
		forever #20 clk48m = ~clk48m;
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input bus_data_t got, input bus_data_t exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_pin(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	function automatic irq_vec_t expect_irq(input logic err, input logic [2:0] ext);
		irq_vec_t v;
		v = '0;
		v[`SOC_IRQ_BUSERR] = err;
		v[`SOC_IRQ_EXT_LSB +: `SOC_IRQ_EXT_W] = ext;
		return v;
	endfunction

	function automatic bus_data_t model_read(input logic [4:0] idx);
		case (idx)
			`SOC_REG_LED: return {16'h0, m_led};
			`SOC_REG_BTN: return {24'h0, ~btn_v};
			`SOC_REG_SOC_VER: return `SOC_VERSION;
			`SOC_REG_FLASH_SEL: return {31'h0, m_fsel_d};
			`SOC_REG_GENIO_IN: return {2'b0, gin_v};
			`SOC_REG_GENIO_OUT: return {2'b0, m_out};
			`SOC_REG_GENIO_OE: return {2'b0, m_oe};
			default: return '0;
		endcase
	endfunction

	task automatic model_write(input logic [4:0] idx, input bus_data_t data);
		case (idx)
			`SOC_REG_LED: m_led = data[`SOC_LED_W-1:0];
			`SOC_REG_FLASH_SEL: m_fsel_d = data[0];
			`SOC_REG_GENIO_OUT: m_out = data[`SOC_GENIO_W-1:0];
			`SOC_REG_GENIO_OE: m_oe = data[`SOC_GENIO_W-1:0];
			`SOC_REG_GENIO_W2S: m_out = m_out | data[`SOC_GENIO_W-1:0];
			`SOC_REG_GENIO_W2C: m_out = m_out & ~data[`SOC_GENIO_W-1:0];
			default: ;
		endcase
	endtask

	// one request, held until o_ready, then valid drops on the next edge
	task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
		input bus_strb_t strb, output bus_data_t rdata, output irq_vec_t irq);
		int   edges;
		logic seen;
		edges = 0;
		seen = 1'b0;
		rnd = $random(seed);
		btn_v = rnd[7:0];
		ext_v = rnd[10:8];
		rnd = $random(seed);
		gin_v = rnd[29:0];
		@(posedge clk48m);
		i_valid <= 1'b1;
		i_addr <= addr;
		i_wdata <= wdata;
		i_wstrb <= strb;
		i_btn <= btn_v;
		i_genio_in <= gin_v;
		i_irq_ext <= ext_v;
		while (!seen) begin
			@(posedge clk48m);
			edges++;
			@(negedge clk48m);
			seen = o_ready;
			if (!seen && edges >= 8) begin
				$display("Timeout at %0t ns: no o_ready within 8 cycles of a request", $time);
				abort_run();
			end
		end
		if (edges != 2) begin
			$display("Fail %0t ns: response %0d cycles after valid, expected 2", $time, edges);
			abort_run();
		end
		rdata = o_rdata;
		irq = o_irq;
		@(posedge clk48m);
		i_valid <= 1'b0;
	endtask

	task automatic do_write(input logic [4:0] idx, input bus_data_t data);
		bus_data_t rdata;
		irq_vec_t  irq;
		bus_strb_t strb;
		rnd = $random(seed);
		strb = rnd[3:0];
		if (strb == 4'h0)
			strb = 4'hC;
		// bits outside 31:28 and 6:2 are don't care
		bus_access({`SOC_REGION_MISC, rnd[24:4], idx, rnd[26:25]}, data, strb, rdata, irq);
		model_write(idx, data);
		check_irq(irq, expect_irq(1'b0, ext_v), "irq during write response");
	endtask

	task automatic do_read(input logic [4:0] idx);
		bus_data_t rdata;
		irq_vec_t  irq;
		rnd = $random(seed);
		bus_access({`SOC_REGION_MISC, rnd[24:4], idx, rnd[26:25]}, rnd, 4'h0, rdata, irq);
		check_data(rdata, model_read(idx), $sformatf("read of index %0d", idx));
		check_irq(irq, expect_irq(1'b0, ext_v), "irq during read response");
	endtask

	task automatic err_access();
		bus_data_t rdata;
		irq_vec_t  irq;
		logic [3:0] region;
		rnd = $random(seed);
		region = rnd[31:28];
		if (region == `SOC_REGION_MISC)
			region[0] = ~region[0];
		bus_access({region, rnd[27:0]}, rnd, rnd[3:0], rdata, irq);
		check_data(rdata, `SOC_ERR_WORD, "bus error read data");
		check_irq(irq, expect_irq(1'b1, ext_v), "irq during bus error");
	endtask

	task automatic watch_fsel_c(output bus_data_t high_cycles);
		high_cycles = '0;
		for (int n = 0; n < 16; n++) begin
			@(negedge clk48m);
			if (o_fsel_c)
				high_cycles = high_cycles + 1;
			check_pin(o_programn, 1'b1, "o_programn after unkeyed write");
		end
	endtask

	initial begin
		int         i;
		int         waited;
		logic [4:0] idx;
		logic [3:0] k;
		bus_data_t  pulse;

		seed = 37130;
		rst <= 1'b1;
		i_valid <= 1'b0;
		i_addr <= '0;
		i_wdata <= '0;
		i_wstrb <= '0;
		i_btn <= '0;
		i_genio_in <= '0;
		i_irq_ext <= '0;
		m_led = '0;
		m_out = '0;
		m_oe = '0;
		m_fsel_d = 1'b0;
		btn_v = '0;
		gin_v = '0;
		ext_v = '0;
		repeat (5) @(posedge clk48m);
		rst <= 1'b0;
		@(negedge clk48m);
		check_pin(o_ready, 1'b0, "o_ready after reset");
		check_pin(o_fsel_c, 1'b0, "o_fsel_c after reset");
		check_pin(o_fsel_d, 1'b0, "o_fsel_d after reset");
		check_pin(o_programn, 1'b1, "o_programn after reset");
		check_data({16'h0, o_led}, '0, "o_led after reset");
		check_data({2'b0, o_genio_out}, '0, "o_genio_out after reset");
		check_data({2'b0, o_genio_oe}, '0, "o_genio_oe after reset");
		check_irq(o_irq, expect_irq(1'b0, 3'b0), "o_irq after reset");

		// led and genio registers
		for (i = 0; i < 60; i++) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0: idx = `SOC_REG_LED;
				2'd1: idx = `SOC_REG_GENIO_OE;
				default: idx = `SOC_REG_GENIO_OUT;
			endcase
			if (rnd[2])
				do_write(idx, $random(seed));
			else
				do_read(idx);
		end
		check_data({16'h0, o_led}, {16'h0, m_led}, "o_led pin");
		check_data({2'b0, o_genio_out}, {2'b0, m_out}, "o_genio_out pin");
		check_data({2'b0, o_genio_oe}, {2'b0, m_oe}, "o_genio_oe pin");

		// set and clear on genio out
		for (i = 0; i < 30; i++) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0: do_write(`SOC_REG_GENIO_W2S, $random(seed));
				2'd1: do_write(`SOC_REG_GENIO_W2C, $random(seed));
				2'd2: do_write(`SOC_REG_GENIO_OUT, $random(seed));
				default: do_read(`SOC_REG_GENIO_OUT);
			endcase
		end
		check_data({2'b0, o_genio_out}, {2'b0, m_out}, "o_genio_out pin after set/clear");

		// unknown indexes 3..12 and 22..31
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			k = rnd[3:0];
			if (k > 4'd9)
				k = k - 4'd6;
			idx = rnd[4] ? 5'd22 + {1'b0, k} : 5'd3 + {1'b0, k};
			if (rnd[5])
				do_write(idx, $random(seed));
			else
				do_read(idx);
		end
		do_read(`SOC_REG_LED);
		do_read(`SOC_REG_GENIO_OUT);
		do_read(`SOC_REG_GENIO_OE);

		// read-only sources
		for (i = 0; i < 10; i++) begin
			do_read(`SOC_REG_BTN);
			do_read(`SOC_REG_GENIO_IN);
			do_read(`SOC_REG_SOC_VER);
		end

		// other regions
		for (i = 0; i < 20; i++)
			err_access();
		do_read(`SOC_REG_LED);
		do_read(`SOC_REG_GENIO_OUT);

		// flash select without the key
		rnd = $random(seed);
		if (rnd[31:8] == `SOC_FSEL_KEY)
			rnd[8] = ~rnd[8];
		rnd[0] = 1'b1;
		do_write(`SOC_REG_FLASH_SEL, rnd);
		check_pin(o_fsel_d, m_fsel_d, "o_fsel_d after flash select write");
		watch_fsel_c(pulse);
		check_data(pulse, 32'd3, "o_fsel_c high cycles");
		do_read(`SOC_REG_FLASH_SEL);

		// keyed write queues the reload
		rnd = $random(seed);
		rnd[31:8] = `SOC_FSEL_KEY;
		do_write(`SOC_REG_FLASH_SEL, rnd);
		waited = 0;
		@(negedge clk48m);
		while (o_programn && waited < 20) begin
			@(negedge clk48m);
			waited++;
		end
		if (o_programn) begin
			$display("Timeout: o_programn stayed high after a keyed flash select write");
			abort_run();
		end
		// a later unkeyed write must not release it
		do_write(`SOC_REG_FLASH_SEL, 32'h0);
		check_pin(o_fsel_d, m_fsel_d, "o_fsel_d after second flash select write");
		for (i = 0; i < 20; i++) begin
			do_read(`SOC_REG_LED);
			check_pin(o_programn, 1'b0, "o_programn after reload");
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: soc_misc.f
+incdir+.
soc_bus_pkg.sv
soc_misc_pkg.sv
bus_decode.sv
reg_execute.sv
fsel_sequencer.sv
read_result.sv
soc_misc.sv
soc_misc_asserts.sv
tb_soc_misc.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_soc_misc -f soc_misc.f -o tb_soc_misc &&
./obj_dir/tb_soc_misc ||
{ echo "simulation failed"; exit 1; }
